// File: flist.f
+incdir+src
src/video_pkg.sv
src/video_timing.sv
src/line_fetch.sv
src/scanline_shade.sv
src/ram2video.sv
sim/ram2video_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the ram2video testbench with Verilator, run it and scan the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f flist.f --top-module ram2video_tb \
    -Mdir obj_dir -o ram2video_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/ram2video_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    echo "failure reported in $LOG"
    exit 1
fi

echo "no failure reported in $LOG"
exit 0

// File: sim/ram2video_tb.sv
/*
 * Testbench for the line-doubled video output stage. Reads scanline settings from
 * sim/video_cases.txt, runs one frame per case and checks timing and pixel data.
 */
`timescale 1ns/10ps
`default_nettype none

`include "video_params.svh"

module ram2video_tb import video_pkg::*; ();

    localparam int SAMPLES = 64;
    localparam int START_TIMEOUT = 16;
    localparam int FRAME_CYCLES = `VID_H_TOTAL * `VID_V_TOTAL;

    logic       clock;
    logic       reset;
    logic       start;
    logic       scanline_enable;
    logic       scanline_odd;
    intensity_t scanline_intensity;
    pixel_t     rddata = '0;
    ram_addr_t  rdaddr;
    pixel_t     video_out;
    logic       hsync;
    logic       vsync;
    logic       draw_area;
    logic       settled;

    logic [31:0] rng_state;
    string       case_name;
    int          case_errors;

    ram2video dut (
        .clock              (clock),
        .reset              (reset),
        .start              (start),
        .scanline_enable    (scanline_enable),
        .scanline_odd       (scanline_odd),
        .scanline_intensity (scanline_intensity),
        .rddata             (rddata),
        .rdaddr             (rdaddr),
        .video_out          (video_out),
        .hsync              (hsync),
        .vsync              (vsync),
        .draw_area          (draw_area),
        .settled            (settled)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // fill pattern spread over the whole address
    function automatic logic [23:0] ram_pattern(input logic [15:0] addr);
        logic [39:0] prod;
        prod = {24'd0, addr} * 40'h00009E3779;
        return prod[23:0];
    endfunction

    // pixel RAM model with one cycle read latency
    always @(posedge clock or posedge reset) begin
        if (reset) begin
            rddata <= '0;
        end else begin
            rddata <= ram_pattern(rdaddr);
        end
    end

    function automatic logic [31:0] xorshift_next();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    // source word for (px,py) darkened per channel on the chosen line parity
    function automatic logic [23:0] expected_pixel(input int px, input int py,
            input logic en, input logic odd, input logic [7:0] k);
        int          addr;
        int          chan;
        logic [23:0] pix;
        logic [15:0] prod;
        addr = (py / `VID_LINE_REPEAT) * `VID_LINE_WORDS + px / `VID_PIXEL_REPEAT;
        pix = ram_pattern(addr[15:0]);
        if (en && (py[0] == odd)) begin
            for (chan = 0; chan < 3; chan++) begin
                prod = {8'd0, pix[chan*8 +: 8]} * {8'd0, k};
                pix[chan*8 +: 8] = prod[15:8];
            end
        end
        return pix;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
            input logic [31:0] actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                case_name, what, expected, actual);
            case_errors++;
        end
    endtask

    ////////////////////
    // one case with reset, start, one frame and then the second vsync
    task automatic run_case(input logic en, input logic odd, input logic [7:0] k);
        int   sx [SAMPLES];
        int   sy [SAMPLES];
        int   i;
        int   cycles;
        int   ox;
        int   oy;
        int   next_sample;
        int   hs_len;
        int   hs_pulses;
        int   hs_fall_at;
        int   vs_low;
        int   draw_cycles;
        logic hs_prev;
        logic vs_prev;
        logic da_prev;

        @(negedge clock);
        scanline_enable = en;
        scanline_odd = odd;
        scanline_intensity = k;
        reset = 1'b1;
        repeat (3) @(negedge clock);
        reset = 1'b0;

        // idle outputs before start
        for (i = 0; i < 4; i++) begin
            @(negedge clock);
            check_value("idle hsync", 32'd1, 32'(hsync));
            check_value("idle vsync", 32'd1, 32'(vsync));
            check_value("idle draw_area", 32'd0, 32'(draw_area));
            check_value("idle video_out", 32'd0, 32'(video_out));
            check_value("idle settled", 32'd0, 32'(settled));
            check_value("idle rdaddr", 32'd0, 32'(rdaddr));
        end

        // one sample per band of 7 lines at a random line within it
        for (i = 0; i < SAMPLES; i++) begin
            sy[i] = i * (`VID_V_VISIBLE / SAMPLES) + int'(xorshift_next() % 32'd7);
            sx[i] = int'(xorshift_next() % 32'(`VID_H_VISIBLE));
        end

        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        cycles = 1;
        while (!draw_area && cycles < START_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        assert (draw_area) else begin
            $display("draw_area did not rise within %0d cycles of start in case %s",
                START_TIMEOUT, case_name);
            case_errors++;
        end
        if (!draw_area) return;
        check_value("first pixel latency", 32'd4, cycles);

        ox = 0;
        oy = 0;
        next_sample = 0;
        hs_len = 0;
        hs_pulses = 0;
        hs_fall_at = -1;
        vs_low = 0;
        draw_cycles = 0;
        hs_prev = 1'b1;
        vs_prev = 1'b1;
        da_prev = 1'b0;
        for (i = 0; i < FRAME_CYCLES; i++) begin
            if (draw_area) draw_cycles++;
            else check_value("blank video_out", 32'd0, 32'(video_out));
            if (!hsync) hs_len++;
            if (!hsync && hs_prev) begin
                if (hs_fall_at >= 0) check_value("line length", `VID_H_TOTAL, i - hs_fall_at);
                hs_fall_at = i;
            end
            if (hsync && !hs_prev) begin
                check_value("hsync width", `VID_H_SYNC_WIDTH, hs_len);
                hs_pulses++;
                hs_len = 0;
            end
            if (!vsync) vs_low++;
            if (!vsync && vs_prev) begin
                check_value("vsync line", `VID_V_SYNC_START, oy);
                check_value("vsync pixel", 32'd0, ox);
            end
            if (draw_area && !da_prev) check_value("draw_area start pixel", 32'd0, ox);
            check_value("settled in first frame", 32'd0, 32'(settled));
            if (next_sample < SAMPLES && ox == sx[next_sample] && oy == sy[next_sample]) begin
                check_value($sformatf("draw_area at (%0d,%0d)", ox, oy), 32'd1, 32'(draw_area));
                check_value($sformatf("pixel at (%0d,%0d)", ox, oy),
                    32'(expected_pixel(ox, oy, en, odd, k)), 32'(video_out));
                next_sample++;
            end
            hs_prev = hsync;
            vs_prev = vsync;
            da_prev = draw_area;
            if (ox == `VID_H_TOTAL - 1) begin
                ox = 0;
                oy = (oy == `VID_V_TOTAL - 1) ? 0 : oy + 1;
            end else begin
                ox++;
            end
            @(negedge clock);
        end
        check_value("hsync pulses", `VID_V_TOTAL, hs_pulses);
        check_value("vsync cycles", `VID_V_SYNC_WIDTH * `VID_H_TOTAL, vs_low);
        check_value("draw_area cycles", `VID_H_VISIBLE * `VID_V_VISIBLE, draw_cycles);

        // settled rises together with the second vsync pulse
        cycles = 0;
        while (vsync && cycles < FRAME_CYCLES) begin
            check_value("settled before second vsync", 32'd0, 32'(settled));
            @(negedge clock);
            cycles++;
        end
        assert (!vsync) else begin
            $display("second vsync pulse did not appear within %0d cycles in case %s",
                FRAME_CYCLES, case_name);
            case_errors++;
        end
        if (!vsync) check_value("settled at second vsync", 32'd1, 32'(settled));
    endtask

    ////////////////////
    // case reader and report
    initial begin
        int    fd;
        int    n;
        int    en_val;
        int    odd_val;
        int    k_val;
        int    pass_cases;
        int    fail_cases;
        string line;

        reset = 1'b1;
        start = 1'b0;
        scanline_enable = 1'b0;
        scanline_odd = 1'b0;
        scanline_intensity = '0;
        rng_state = 32'd17;
        pass_cases = 0;
        fail_cases = 0;

        fd = $fopen("sim/video_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file sim/video_cases.txt");
            fail_cases++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %d %d %d", case_name, en_val, odd_val, k_val);
                if (n == 4 && line.getc(0) != 8'h23) begin
                    case_errors = 0;
                    run_case(en_val[0], odd_val[0], k_val[7:0]);
                    if (case_errors == 0) begin
                        $display("case %s passed", case_name);
                        pass_cases++;
                    end else begin
                        $display("case %s failed with %0d errors", case_name, case_errors);
                        fail_cases++;
                    end
                end
            end
            $fclose(fd);
        end

        $display("cases passed: %0d, cases failed: %0d", pass_cases, fail_cases);
        if (fail_cases == 0 && pass_cases > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/video_cases.txt
# columns: case name, scanline_enable, scanline_odd, scanline_intensity
# all values decimal, one case per line
plain_off 0 0 0
off_odd_set 0 1 200
even_half 1 0 128
odd_half 1 1 128
even_black 1 0 0
odd_near_full 1 1 255
odd_quarter 1 1 64
even_dim 1 0 17

// File: src/line_fetch.sv
/*
 * Turns raster positions into pixel RAM addresses with 4x pixel and 2x line repeat.
 * Also delays the raster flags by two cycles so they meet the RAM read data.
 */
`timescale 1ns/10ps
`default_nettype none

`include "video_params.svh"

module line_fetch import video_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  coord_t    x,
    input  coord_t    y,
    input  logic      line_odd,
    input  logic      visible,
    input  logic      hsync_raw,
    input  logic      vsync_raw,
    output ram_addr_t rdaddr,
    output logic      visible_d,
    output logic      hsync_d,
    output logic      vsync_d,
    output logic      line_odd_d
);

    localparam int PIX_REP_W = $clog2(`VID_PIXEL_REPEAT);
    localparam int LINE_REP_W = $clog2(`VID_LINE_REPEAT);
    // base address of the last source line in the buffer
    localparam int LAST_BASE = (`VID_V_VISIBLE / `VID_LINE_REPEAT - 1) * `VID_LINE_WORDS;

    // counters describe the position currently on x and y
    logic [PIX_REP_W-1:0]  pix_rep;
    logic [LINE_REP_W-1:0] line_rep;
    ram_addr_t             word_cnt;
    ram_addr_t             line_base;

    logic visible_q;
    logic hsync_q;
    logic vsync_q;
    logic line_odd_q;

    ////////////////////
    // address generation
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pix_rep <= '0;
            line_rep <= '0;
            word_cnt <= '0;
            line_base <= '0;
            rdaddr <= '0;
        end else begin
            rdaddr <= visible ? line_base + word_cnt : '0;

            if (x == coord_t'(`VID_H_TOTAL - 1)) begin
                // next position is x = 0
                pix_rep <= '0;
                word_cnt <= '0;
                if (y == coord_t'(`VID_V_TOTAL - 1)) begin
                    line_rep <= '0;
                    line_base <= '0;
                end else if (y < coord_t'(`VID_V_VISIBLE)) begin
                    if (line_rep == LINE_REP_W'(`VID_LINE_REPEAT - 1)) begin
                        line_rep <= '0;
                        if (line_base < ram_addr_t'(LAST_BASE)) begin
                            line_base <= line_base + ram_addr_t'(`VID_LINE_WORDS);
                        end
                    end else begin
                        line_rep <= line_rep + 1'b1;
                    end
                end
            end else if (visible) begin
                if (pix_rep == PIX_REP_W'(`VID_PIXEL_REPEAT - 1)) begin
                    pix_rep <= '0;
                    if (word_cnt < ram_addr_t'(`VID_LINE_WORDS - 1)) begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end else begin
                    pix_rep <= pix_rep + 1'b1;
                end
            end
        end
    end

    ////////////////////
    // flags wait for address register plus RAM latency
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            visible_q <= 1'b0;
            hsync_q <= ~`VID_SYNC_ACTIVE;
            vsync_q <= ~`VID_SYNC_ACTIVE;
            line_odd_q <= 1'b0;
            visible_d <= 1'b0;
            hsync_d <= ~`VID_SYNC_ACTIVE;
            vsync_d <= ~`VID_SYNC_ACTIVE;
            line_odd_d <= 1'b0;
        end else begin
            visible_q <= visible;
            hsync_q <= hsync_raw;
            vsync_q <= vsync_raw;
            line_odd_q <= line_odd;
            visible_d <= visible_q;
            hsync_d <= hsync_q;
            vsync_d <= vsync_q;
            line_odd_d <= line_odd_q;
        end
    end

endmodule

`default_nettype wire

// File: src/ram2video.sv
/*
 * Top of the line-doubled video output stage. Connect rdaddr and rddata
 * to a synchronous pixel RAM with one cycle of read latency.
 */
`timescale 1ns/10ps
`default_nettype none

`include "video_params.svh"

module ram2video import video_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       start,
    input  logic       scanline_enable,
    input  logic       scanline_odd,
    input  intensity_t scanline_intensity,
    input  pixel_t     rddata,
    output ram_addr_t  rdaddr,
    output pixel_t     video_out,
    output logic       hsync,
    output logic       vsync,
    output logic       draw_area,
    output logic       settled
);

    // raster position and its decode
    coord_t x;
    coord_t y;
    logic   line_odd;
    logic   visible;
    logic   hsync_raw;
    logic   vsync_raw;

    // flags aligned with rddata
    logic visible_d;
    logic hsync_d;
    logic vsync_d;
    logic line_odd_d;

    video_timing u_timing (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .x         (x),
        .y         (y),
        .line_odd  (line_odd),
        .visible   (visible),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw),
        .settled   (settled)
    );

    line_fetch u_fetch (
        .clock      (clock),
        .reset      (reset),
        .x          (x),
        .y          (y),
        .line_odd   (line_odd),
        .visible    (visible),
        .hsync_raw  (hsync_raw),
        .vsync_raw  (vsync_raw),
        .rdaddr     (rdaddr),
        .visible_d  (visible_d),
        .hsync_d    (hsync_d),
        .vsync_d    (vsync_d),
        .line_odd_d (line_odd_d)
    );

    scanline_shade u_shade (
        .clock              (clock),
        .reset              (reset),
        .rddata             (rddata),
        .visible_d          (visible_d),
        .hsync_d            (hsync_d),
        .vsync_d            (vsync_d),
        .line_odd_d         (line_odd_d),
        .scanline_enable    (scanline_enable),
        .scanline_odd       (scanline_odd),
        .scanline_intensity (scanline_intensity),
        .video_out          (video_out),
        .hsync              (hsync),
        .vsync              (vsync),
        .draw_area          (draw_area)
    );

endmodule

`default_nettype wire

// File: src/scanline_shade.sv
/*
 * Output stage: darkens the chosen scanlines, blanks outside the visible
 * area and registers pixel data together with the sync and draw flags.
 */
`timescale 1ns/10ps
`default_nettype none

`include "video_params.svh"

module scanline_shade import video_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  pixel_t     rddata,
    input  logic       visible_d,
    input  logic       hsync_d,
    input  logic       vsync_d,
    input  logic       line_odd_d,
    input  logic       scanline_enable,
    input  logic       scanline_odd,
    input  intensity_t scanline_intensity,
    output pixel_t     video_out,
    output logic       hsync,
    output logic       vsync,
    output logic       draw_area
);

    logic   darken;
    pixel_t shaded;

    // scale one 8 bit channel, keep the upper byte of the product
    function automatic logic [7:0] shade_channel(input logic [7:0] c, input intensity_t k);
        logic [15:0] prod;
        prod = c * k;
        return prod[15:8];
    endfunction

    assign darken = scanline_enable && (line_odd_d == scanline_odd);

    assign shaded = {shade_channel(rddata[23:16], scanline_intensity),
                     shade_channel(rddata[15:8], scanline_intensity),
                     shade_channel(rddata[7:0], scanline_intensity)};

    ////////////////////
    // output registers
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            video_out <= '0;
            hsync <= ~`VID_SYNC_ACTIVE;
            vsync <= ~`VID_SYNC_ACTIVE;
            draw_area <= 1'b0;
        end else begin
            if (!visible_d) begin
                video_out <= '0;
            end else if (darken) begin
                video_out <= shaded;
            end else begin
                video_out <= rddata;
            end
            hsync <= hsync_d;
            vsync <= vsync_d;
            draw_area <= visible_d;
        end
    end

endmodule

`default_nettype wire

// File: src/video_params.svh
/*
 * Raster, sync and frame buffer geometry of the 640 x 480 output stage.
 * Include this wherever the timing or buffer constants are needed.
 */
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

////////////////////
// horizontal raster, in pixels
`define VID_H_TOTAL 800
`define VID_H_VISIBLE 640
`define VID_H_SYNC_START 656
`define VID_H_SYNC_WIDTH 96

////////////////////
// vertical raster, in lines
`define VID_V_TOTAL 525
`define VID_V_VISIBLE 480
`define VID_V_SYNC_START 490
`define VID_V_SYNC_WIDTH 2

// negative polarity on both syncs
`define VID_SYNC_ACTIVE 1'b0

////////////////////
// source buffer layout
`define VID_LINE_WORDS 160
// each source word covers this many output pixels
`define VID_PIXEL_REPEAT 4
// each source line covers this many output lines
`define VID_LINE_REPEAT 2

// vsync pulses seen before the output counts as settled
`define VID_SETTLE_VSYNCS 2

`endif

// File: src/video_pkg.sv
/*
 * Shared vector types and the timing state encoding of the video stage.
 */
`default_nettype none

package video_pkg;

    // rgb, red in the top byte
    typedef logic [23:0] pixel_t;

    // pixel or line position on the raster
    typedef logic [11:0] coord_t;

    // word address into the pixel RAM
    typedef logic [15:0] ram_addr_t;

    // scanline brightness, 255 is nearly full
    typedef logic [7:0] intensity_t;

    typedef enum logic {
        TIMING_IDLE,
        TIMING_RUN
    } timing_state_t;

endpackage

`default_nettype wire

// File: src/video_timing.sv
/*
 * Raster generator: waits for start, then scans 800 x 525 forever.
 * Decodes sync and visible flags from the counters and flags a settled output.
 */
`timescale 1ns/10ps
`default_nettype none

`include "video_params.svh"

module video_timing import video_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  logic   start,
    output coord_t x,
    output coord_t y,
    output logic   line_odd,
    output logic   visible,
    output logic   hsync_raw,
    output logic   vsync_raw,
    output logic   settled
);

    localparam int VS_CNT_W = $clog2(`VID_SETTLE_VSYNCS + 1);

    timing_state_t state;

    logic                running;
    logic                hsync_window;
    logic                vsync_active;
    logic                vsync_prev;
    logic                vsync_start;
    logic [VS_CNT_W-1:0] vsync_count;
    logic                settle_now;
    // lines settled up with the 3 cycle output path
    logic [2:0]          settle_pipe;

    ////////////////////
    // start trigger and counters
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= TIMING_IDLE;
            x <= '0;
            y <= '0;
        end else begin
            case (state)
                TIMING_IDLE: begin
                    if (start) begin
                        state <= TIMING_RUN;
                        x <= '0;
                        y <= '0;
                    end
                end
                TIMING_RUN: begin
                    if (x == coord_t'(`VID_H_TOTAL - 1)) begin
                        x <= '0;
                        if (y == coord_t'(`VID_V_TOTAL - 1)) begin
                            y <= '0;
                        end else begin
                            y <= y + 1'b1;
                        end
                    end else begin
                        x <= x + 1'b1;
                    end
                end
                default: state <= TIMING_IDLE;
            endcase
        end
    end

    ////////////////////
    // decode of the current position
    assign running = (state == TIMING_RUN);

    assign hsync_window = (x >= coord_t'(`VID_H_SYNC_START))
        && (x < coord_t'(`VID_H_SYNC_START + `VID_H_SYNC_WIDTH));

    assign vsync_active = running && (y >= coord_t'(`VID_V_SYNC_START))
        && (y < coord_t'(`VID_V_SYNC_START + `VID_V_SYNC_WIDTH));

    assign visible = running && (x < coord_t'(`VID_H_VISIBLE))
        && (y < coord_t'(`VID_V_VISIBLE));

    assign hsync_raw = (running && hsync_window) ? `VID_SYNC_ACTIVE : ~`VID_SYNC_ACTIVE;
    assign vsync_raw = vsync_active ? `VID_SYNC_ACTIVE : ~`VID_SYNC_ACTIVE;
    assign line_odd = y[0];

    ////////////////////
    // settled flag from counted vsync pulses
    assign vsync_start = vsync_active && !vsync_prev;

    // true already in the first cycle of the deciding pulse
    assign settle_now = (vsync_count == VS_CNT_W'(`VID_SETTLE_VSYNCS))
        || (vsync_start && vsync_count == VS_CNT_W'(`VID_SETTLE_VSYNCS - 1));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            vsync_prev <= 1'b0;
            vsync_count <= '0;
            settle_pipe <= '0;
        end else begin
            vsync_prev <= vsync_active;
            if (vsync_start && vsync_count != VS_CNT_W'(`VID_SETTLE_VSYNCS)) begin
                vsync_count <= vsync_count + 1'b1;
            end
            settle_pipe <= {settle_pipe[1:0], settle_now};
        end
    end

    assign settled = settle_pipe[2];

endmodule

`default_nettype wire
